// ==== verilog/dsp_pkg.sv ====
/* dsp hub definitions
   sample widths, source and sink numbering, register map and bus structs */
package dsp_pkg;

   localparam int SAMPLE_W = 14;  // adc/dac sample width
   localparam int SEL_W    = 4;   // width of a source index
   localparam int BUS_W    = 32;  // bus address and data width

   typedef logic signed [SAMPLE_W-1:0] sample_t;  // one signal sample
   typedef logic [SEL_W-1:0]           sel_t;     // source index
   typedef logic [1:0]                 out_sel_t; // bit0 dac a, bit1 dac b

   localparam sel_t NONE_SEL = 4'd15;  // no source, sink reads zero

   // dac enable codes
   localparam out_sel_t OUT_OFF  = 2'b00;
   localparam out_sel_t OUT_A    = 2'b01;
   localparam out_sel_t OUT_B    = 2'b10;
   localparam out_sel_t OUT_BOTH = 2'b11;

   // sources: blocks take 0..N_BLOCKS-1, these follow at N_BLOCKS + offset
   localparam int SRC_ASG1  = 0;
   localparam int SRC_ASG2  = 1;
   localparam int SRC_ADC_A = 2;
   localparam int SRC_ADC_B = 3;
   localparam int SRC_DAC_A = 4;  // registered dac outputs fed back
   localparam int SRC_DAC_B = 5;

   // sinks after the block inputs
   localparam int SNK_SCOPE1 = 0;
   localparam int SNK_SCOPE2 = 1;
   localparam int SNK_PWM0   = 2;
   localparam int SNK_PWM1   = 3;

   // register offsets, addr[15:0]
   localparam logic [15:0] REG_INPUT_SEL  = 16'h0000;  // slot = sink
   localparam logic [15:0] REG_OUTPUT_SEL = 16'h0004;  // slot = direct channel
   localparam logic [15:0] REG_SAT        = 16'h0008;  // saturation flags, read only
   localparam logic [15:0] REG_SYNC       = 16'h000C;  // block enables
   localparam logic [15:0] REG_SIGNAL     = 16'h0010;  // slot = source, read only

   typedef struct packed {
      logic [BUS_W-1:0] addr;   // [19:16] slot, [15:0] offset
      logic [BUS_W-1:0] wdata;
      logic             wen;
      logic             ren;
   } bus_req_t;

   typedef struct packed {
      logic [BUS_W-1:0] rdata;
      logic             ack;    // one cycle after the request
      logic             err;    // undecoded offset
   } bus_rsp_t;

endpackage

// ==== verilog/dsp_regs.sv ====
/* hub register bank
   bus decode, routing and dac enable tables, sync register and readback */
`timescale 1ns/1ns

module dsp_regs import dsp_pkg::*; #(
   parameter int N_BLOCKS = 4
) (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  bus_req_t                 bus_req_i,
   input  logic [1:0]               sat_i,          // {dac b, dac a}
   input  sample_t                  signal_i,       // source picked by signal_slot_o
   output bus_rsp_t                 bus_rsp_o,
   output sel_t     [N_BLOCKS+3:0]  in_sel_o,       // one per sink
   output out_sel_t [N_BLOCKS+1:0]  out_sel_o,      // one per direct channel
   output logic     [N_BLOCKS-1:0]  sync_o,
   output sel_t                     signal_slot_o
);

   localparam int N_SNK = N_BLOCKS + SNK_PWM1 + 1;  // blocks + scopes + pwm
   localparam int N_DIR = N_BLOCKS + 2;             // blocks + both generators

   localparam sel_t ADC_A_IDX = sel_t'(N_BLOCKS + SRC_ADC_A);
   localparam sel_t ADC_B_IDX = sel_t'(N_BLOCKS + SRC_ADC_B);

   sel_t     [N_SNK-1:0]    in_sel_q;
   out_sel_t [N_DIR-1:0]    out_sel_q;
   logic     [N_BLOCKS-1:0] sync_q;

   logic              req;      // any access this cycle
   logic              hit;      // offset is decoded
   sel_t              slot;
   logic [15:0]       offset;
   logic [BUS_W-1:0]  rdata_d;
   logic [BUS_W-1:0]  rdata_q;
   logic              ack_q;
   logic              err_q;

   assign req    = bus_req_i.wen | bus_req_i.ren;
   assign slot   = bus_req_i.addr[19:16];
   assign offset = bus_req_i.addr[15:0];

   assign signal_slot_o = slot;  // router looks up the source for readback

   // config tables, writes land on the ack edge
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < N_BLOCKS; k++) begin
            in_sel_q[k] <= ADC_A_IDX;  // every block listens to adc a
         end
         in_sel_q[N_BLOCKS+SNK_SCOPE1] <= ADC_A_IDX;
         in_sel_q[N_BLOCKS+SNK_SCOPE2] <= ADC_B_IDX;
         in_sel_q[N_BLOCKS+SNK_PWM0]   <= NONE_SEL;   // pwm silent
         in_sel_q[N_BLOCKS+SNK_PWM1]   <= NONE_SEL;
         out_sel_q <= {N_DIR{OUT_OFF}};              // nothing summed into dacs
         sync_q    <= '1;                            // all blocks enabled
      end else if (bus_req_i.wen) begin
         case (offset)
            REG_INPUT_SEL: begin
               if (slot < N_SNK) begin
                  in_sel_q[slot] <= bus_req_i.wdata[SEL_W-1:0];
               end
            end
            REG_OUTPUT_SEL: begin
               if (slot < N_DIR) begin
                  out_sel_q[slot] <= bus_req_i.wdata[1:0];
               end
            end
            REG_SYNC: sync_q <= bus_req_i.wdata[N_BLOCKS-1:0];
            default: ;  // read-only or undecoded, nothing stored
         endcase
      end
   end

   // read mux, also flags undecoded offsets
   always_comb begin
      rdata_d = '0;
      hit     = 1'b1;
      case (offset)
         REG_INPUT_SEL: begin
            if (slot < N_SNK) rdata_d[SEL_W-1:0] = in_sel_q[slot];
         end
         REG_OUTPUT_SEL: begin
            if (slot < N_DIR) rdata_d[1:0] = out_sel_q[slot];
         end
         REG_SAT:    rdata_d[1:0] = sat_i;
         REG_SYNC:   rdata_d[N_BLOCKS-1:0] = sync_q;
         REG_SIGNAL: rdata_d = {{(BUS_W-SAMPLE_W){signal_i[SAMPLE_W-1]}}, signal_i};  // sign ext
         default:    hit = 1'b0;  // answered with err, data zero
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req;         // fixed one-cycle answer
         err_q <= req & ~hit;
      end
   end

   always_ff @(posedge clk_i) begin
      rdata_q <= rdata_d;
   end

   assign bus_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};
   assign in_sel_o  = in_sel_q;
   assign out_sel_o = out_sel_q;
   assign sync_o    = sync_q;

   // every ack belongs to its own request
   a_ack_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
      bus_rsp_o.ack && !req |=> !bus_rsp_o.ack);

endmodule

// ==== verilog/dsp_router.sv ====
/* signal crossbar
   picks one source for every sink and for the bus readback slot */
`timescale 1ns/1ns

module dsp_router import dsp_pkg::*; #(
   parameter int N_BLOCKS = 4
) (
   input  sample_t [N_BLOCKS-1:0]  blk_out_i,   // external block outputs
   input  sample_t                 asg1_i,
   input  sample_t                 asg2_i,
   input  sample_t                 adc_a_i,
   input  sample_t                 adc_b_i,
   input  sample_t                 dac_a_i,     // registered dac, fed back
   input  sample_t                 dac_b_i,
   input  sel_t    [N_BLOCKS+3:0]  in_sel_i,    // one index per sink
   input  sel_t                    signal_slot_i,
   output sample_t [N_BLOCKS-1:0]  blk_in_o,
   output sample_t                 scope1_o,
   output sample_t                 scope2_o,
   output sample_t                 pwm0_o,
   output sample_t                 pwm1_o,
   output sample_t                 signal_o     // for REG_SIGNAL
);

   localparam int N_SRC = N_BLOCKS + SRC_DAC_B + 1;  // never above 15
   localparam int N_SNK = N_BLOCKS + SNK_PWM1 + 1;

   sample_t [N_SRC-1:0] src;  // source list in package numbering
   sample_t [N_SNK-1:0] snk;  // routed value per sink

   // out of range or none gives zero
   function automatic sample_t pick(input sample_t [N_SRC-1:0] list, input sel_t sel);
      if (sel == NONE_SEL || sel >= N_SRC) begin
         return '0;
      end
      return list[sel];
   endfunction

   assign src[N_BLOCKS-1:0]        = blk_out_i;
   assign src[N_BLOCKS+SRC_ASG1]  = asg1_i;
   assign src[N_BLOCKS+SRC_ASG2]  = asg2_i;
   assign src[N_BLOCKS+SRC_ADC_A] = adc_a_i;
   assign src[N_BLOCKS+SRC_ADC_B] = adc_b_i;
   assign src[N_BLOCKS+SRC_DAC_A] = dac_a_i;
   assign src[N_BLOCKS+SRC_DAC_B] = dac_b_i;

   // one mux per sink, purely combinational
   for (genvar k = 0; k < N_SNK; k++) begin : g_snk
      assign snk[k] = pick(src, in_sel_i[k]);
   end

   assign blk_in_o = snk[N_BLOCKS-1:0];
   assign scope1_o = snk[N_BLOCKS+SNK_SCOPE1];
   assign scope2_o = snk[N_BLOCKS+SNK_SCOPE2];
   assign pwm0_o   = snk[N_BLOCKS+SNK_PWM0];
   assign pwm1_o   = snk[N_BLOCKS+SNK_PWM1];

   assign signal_o = pick(src, signal_slot_i);  // bus readback tap

endmodule

// ==== verilog/dac_sum_tree.sv ====
/* dac summing pipeline
   gated adder tree per dac with a registered saturation stage */
`timescale 1ns/1ns

module dac_sum_tree import dsp_pkg::*; #(
   parameter int N_BLOCKS = 4
) (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  sample_t  [N_BLOCKS+1:0]  direct_i,   // blocks then asg1, asg2
   input  out_sel_t [N_BLOCKS+1:0]  out_sel_i,  // per channel dac enables
   output sample_t                  dac_a_o,
   output sample_t                  dac_b_o,
   output logic     [1:0]           sat_o       // {dac b, dac a}
);

   localparam int N_DIR = N_BLOCKS + 2;
   localparam int LVL   = $clog2(N_DIR);   // tree depth, latency is LVL + 2
   localparam int N_PAD = 2 ** LVL;        // channel count rounded up
   localparam int SUM_W = SAMPLE_W + LVL;  // no overflow inside the tree

   typedef logic signed [SUM_W-1:0] acc_t;

   localparam sample_t S_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};  // +8191
   localparam sample_t S_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};  // -8192

   sample_t  [N_PAD-1:0] dir_pad;
   out_sel_t [N_PAD-1:0] sel_pad;
   sample_t  [1:0]       dac_q;
   logic     [1:0]       sat_q;

   // sign extend and gate one channel
   function automatic acc_t gate(input sample_t s, input logic en);
      acc_t ext;
      ext = {{LVL{s[SAMPLE_W-1]}}, s};
      return en ? ext : '0;
   endfunction

   // pad to a power of two with disabled zero channels
   for (genvar c = 0; c < N_PAD; c++) begin : g_pad
      if (c < N_DIR) begin : g_live
         assign dir_pad[c] = direct_i[c];
         assign sel_pad[c] = out_sel_i[c];
      end else begin : g_zero
         assign dir_pad[c] = '0;
         assign sel_pad[c] = OUT_OFF;
      end
   end

   // same tree for both dacs, d selects the enable bit
   for (genvar d = 0; d < 2; d++) begin : g_dac
      acc_t    node [N_PAD-1:1];  // heap order, node k sums 2k and 2k+1
      acc_t    root_q;            // extra stage before the clamp
      sample_t clamp;
      logic    over;

      always_ff @(posedge clk_i) begin
         if (!rstn_i) begin
            for (int k = 1; k < N_PAD; k++) begin
               node[k] <= '0;
            end
            root_q <= '0;
         end else begin
            // leaves: gated pair sums of the inputs
            for (int k = N_PAD/2; k < N_PAD; k++) begin
               node[k] <= gate(dir_pad[2*(k-N_PAD/2)],   sel_pad[2*(k-N_PAD/2)][d])
                        + gate(dir_pad[2*(k-N_PAD/2)+1], sel_pad[2*(k-N_PAD/2)+1][d]);
            end
            // one tree level per cycle
            for (int k = 1; k < N_PAD/2; k++) begin
               node[k] <= node[2*k] + node[2*k+1];
            end
            root_q <= node[1];
         end
      end

      // clamp to 14 bit signed range
      always_comb begin
         over = 1'b1;
         if (root_q > S_MAX) begin
            clamp = S_MAX;
         end else if (root_q < S_MIN) begin
            clamp = S_MIN;
         end else begin
            clamp = root_q[SAMPLE_W-1:0];
            over  = 1'b0;
         end
      end

      always_ff @(posedge clk_i) begin
         if (!rstn_i) begin
            dac_q[d] <= '0;
            sat_q[d] <= 1'b0;
         end else begin
            dac_q[d] <= clamp;
            sat_q[d] <= over;  // flag travels with the clamped sample
         end
      end

      // flagged sample sits on a rail
      a_sat_rail: assert property (@(posedge clk_i) disable iff (!rstn_i)
         sat_q[d] |-> (dac_q[d] == S_MAX || dac_q[d] == S_MIN));
   end

   assign dac_a_o = dac_q[0];
   assign dac_b_o = dac_q[1];
   assign sat_o   = sat_q;

endmodule

// ==== verilog/dsp_hub.sv ====
/* servo signal routing hub
   register bank, crossbar and dac adder tree */
`timescale 1ns/1ns

module dsp_hub import dsp_pkg::*; #(
   parameter int N_BLOCKS = 4  // 1..9 external blocks
) (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  sample_t                  adc_a_i,
   input  sample_t                  adc_b_i,
   input  sample_t                  asg1_i,
   input  sample_t                  asg2_i,
   input  sample_t [N_BLOCKS-1:0]   blk_out_i,
   input  bus_req_t                 bus_req_i,
   output sample_t [N_BLOCKS-1:0]   blk_in_o,
   output sample_t                  scope1_o,
   output sample_t                  scope2_o,
   output sample_t                  pwm0_o,
   output sample_t                  pwm1_o,
   output sample_t                  dac_a_o,
   output sample_t                  dac_b_o,
   output logic    [N_BLOCKS-1:0]   sync_o,
   output bus_rsp_t                 bus_rsp_o
);

   // sources must fit below NONE_SEL
   if (N_BLOCKS < 1 || N_BLOCKS > 9) begin : g_bad_cfg
      $error("N_BLOCKS must be 1 to 9");
   end

   sel_t     [N_BLOCKS+3:0] in_sel;   // routing per sink
   out_sel_t [N_BLOCKS+1:0] out_sel;  // dac enables per direct channel
   sample_t  [N_BLOCKS+1:0] direct;   // blocks, asg1, asg2
   logic     [1:0]          sat;
   sample_t                 signal;
   sel_t                    signal_slot;

   assign direct[N_BLOCKS-1:0]       = blk_out_i;
   assign direct[N_BLOCKS+SRC_ASG1] = asg1_i;
   assign direct[N_BLOCKS+SRC_ASG2] = asg2_i;

   dsp_regs #(.N_BLOCKS(N_BLOCKS)) i_regs (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .bus_req_i     (bus_req_i),
      .sat_i         (sat),
      .signal_i      (signal),
      .bus_rsp_o     (bus_rsp_o),
      .in_sel_o      (in_sel),
      .out_sel_o     (out_sel),
      .sync_o        (sync_o),
      .signal_slot_o (signal_slot)
   );

   dsp_router #(.N_BLOCKS(N_BLOCKS)) i_router (
      .blk_out_i     (blk_out_i),
      .asg1_i        (asg1_i),
      .asg2_i        (asg2_i),
      .adc_a_i       (adc_a_i),
      .adc_b_i       (adc_b_i),
      .dac_a_i       (dac_a_o),      // loop back registered dacs
      .dac_b_i       (dac_b_o),
      .in_sel_i      (in_sel),
      .signal_slot_i (signal_slot),
      .blk_in_o      (blk_in_o),
      .scope1_o      (scope1_o),
      .scope2_o      (scope2_o),
      .pwm0_o        (pwm0_o),
      .pwm1_o        (pwm1_o),
      .signal_o      (signal)
   );

   dac_sum_tree #(.N_BLOCKS(N_BLOCKS)) i_sum (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .direct_i  (direct),
      .out_sel_i (out_sel),
      .dac_a_o   (dac_a_o),
      .dac_b_o   (dac_b_o),
      .sat_o     (sat)
   );

endmodule

// ==== testbench/tb_dsp_vectors.svh ====
/* dsp hub test table
   bus accesses with expected data, steady rows checked against the routing model */
`ifndef TB_DSP_VECTORS_SVH
`define TB_DSP_VECTORS_SVH

function automatic void build_table();
   // reset defaults, sources 0..3 blocks, 4/5 asg, 6/7 adc, 8/9 dac
   steady_row(100, -200, 0, 0, 0, 0, 0, 0);
   read_row(0, REG_INPUT_SEL, 6, 0);    // block 0 on adc a
   read_row(4, REG_INPUT_SEL, 6, 0);    // scope1 on adc a
   read_row(5, REG_INPUT_SEL, 7, 0);    // scope2 on adc b
   read_row(7, REG_INPUT_SEL, 15, 0);   // pwm1 unrouted
   read_row(5, REG_OUTPUT_SEL, 0, 0);
   read_row(0, REG_SYNC, 15, 0);
   // new source for every sink
   write_row(0, REG_INPUT_SEL, 4);      // block 0 from asg1
   write_row(1, REG_INPUT_SEL, 9);      // block 1 from dac b
   write_row(2, REG_INPUT_SEL, 3);
   write_row(3, REG_INPUT_SEL, 7);
   write_row(4, REG_INPUT_SEL, 0);
   write_row(5, REG_INPUT_SEL, 5);
   write_row(6, REG_INPUT_SEL, 12);     // past the last source
   write_row(7, REG_INPUT_SEL, 8);      // pwm1 from dac a
   write_row(9, REG_INPUT_SEL, 1);      // no such sink, dropped
   read_row(6, REG_INPUT_SEL, 12, 0);
   steady_row(300, -400, 55, -66, 11, -22, 33, -44);
   // dac enables, 1 = a, 2 = b, 3 = both
   write_row(0, REG_OUTPUT_SEL, 1);
   write_row(1, REG_OUTPUT_SEL, 2);
   write_row(2, REG_OUTPUT_SEL, 3);
   write_row(4, REG_OUTPUT_SEL, 1);
   write_row(5, REG_OUTPUT_SEL, 2);
   read_row(2, REG_OUTPUT_SEL, 3, 0);
   steady_row(300, -400, 55, -66, 11, -22, 33, -44);  // a 99, b -55
   random_row();
   random_row();
   random_row();
   // saturation both ways
   steady_row(0, 0, 100, 0, 8000, 0, 8000, 0);        // a rails high
   read_row(0, REG_SAT, 1, 0);
   steady_row(0, 0, 0, -500, 0, -8000, -8000, 0);     // b rails low
   read_row(0, REG_SAT, 2, 0);
   steady_row(300, -400, 55, -66, 11, -22, 33, -44);
   read_row(0, REG_SAT, 0, 0);                        // flags clear again
   // signal readback, sync and undecoded offsets
   read_row(3, REG_SIGNAL, -44, 0);
   read_row(6, REG_SIGNAL, 300, 0);
   read_row(8, REG_SIGNAL, 99, 0);      // dac a fed back
   read_row(11, REG_SIGNAL, 0, 0);
   read_row(15, REG_SIGNAL, 0, 0);
   write_row(0, REG_SYNC, 5);
   read_row(0, REG_SYNC, 5, 0);
   random_row();                        // sync_o checked here too
   read_row(0, 16'h0014, 0, 1);
   read_row(2, 16'h0100, 0, 1);
endfunction

`endif

// ==== testbench/tb_dsp_hub.sv ====
/* dsp hub testbench
   table driven bus accesses and steady checks against a routing and sum model */
`timescale 1ns/1ns

module tb_dsp_hub import dsp_pkg::*; ();

   localparam int N_BLOCKS = 4;
   localparam int CLK_HALF = 4;   // 8 ns period

   localparam logic [1:0] K_WR  = 2'd0;  // bus write
   localparam logic [1:0] K_RD  = 2'd1;  // bus read, data is the expected rdata
   localparam logic [1:0] K_CHK = 2'd2;  // steady state, inputs from the row
   localparam logic [1:0] K_RND = 2'd3;  // steady state, inputs from the lcg

   typedef struct packed {
      logic [1:0]             kind;
      logic [31:0]            addr;
      logic [31:0]            data;
      logic                   err;   // expected err flag
      sample_t                adc_a;
      sample_t                adc_b;
      sample_t                asg1;
      sample_t                asg2;
      sample_t [N_BLOCKS-1:0] blk;
   } row_t;

   logic                   clk_i = 1'b0;
   logic                   rstn_i;
   sample_t                adc_a_i, adc_b_i, asg1_i, asg2_i;
   sample_t [N_BLOCKS-1:0] blk_out_i;
   bus_req_t               bus_req_i;
   sample_t [N_BLOCKS-1:0] blk_in_o;
   sample_t                scope1_o, scope2_o, pwm0_o, pwm1_o, dac_a_o, dac_b_o;
   logic    [N_BLOCKS-1:0] sync_o;
   bus_rsp_t               bus_rsp_o;

   sel_t                m_in_sel  [N_BLOCKS+4];  // model of the routing table
   out_sel_t            m_out_sel [N_BLOCKS+2];
   logic [N_BLOCKS-1:0] m_sync;
   logic [31:0]         seed = 32'h0a2ec6e3;
   row_t                rows [$];

   always #CLK_HALF clk_i = ~clk_i;

   dsp_hub #(.N_BLOCKS(N_BLOCKS)) i_dut (
      .clk_i, .rstn_i, .adc_a_i, .adc_b_i, .asg1_i, .asg2_i, .blk_out_i, .bus_req_i,
      .blk_in_o, .scope1_o, .scope2_o, .pwm0_o, .pwm1_o, .dac_a_o, .dac_b_o, .sync_o,
      .bus_rsp_o
   );

   function automatic logic [31:0] reg_addr(input int slot, input logic [15:0] off);
      return {12'd0, 4'(slot), off};
   endfunction

   function automatic void write_row(input int slot, input logic [15:0] off, input int data);
      row_t r;
      r      = '0;
      r.kind = K_WR;
      r.addr = reg_addr(slot, off);
      r.data = data;
      rows.push_back(r);
   endfunction

   function automatic void read_row(input int slot, input logic [15:0] off, input int data,
                                    input int err);
      row_t r;
      r      = '0;
      r.kind = K_RD;
      r.addr = reg_addr(slot, off);
      r.data = data;
      r.err  = (err != 0);
      rows.push_back(r);
   endfunction

   function automatic void steady_row(input int a, input int b, input int g1, input int g2,
                                      input int b0, input int b1, input int b2, input int b3);
      row_t r;
      r        = '0;
      r.kind   = K_CHK;
      r.adc_a  = sample_t'(a);
      r.adc_b  = sample_t'(b);
      r.asg1   = sample_t'(g1);
      r.asg2   = sample_t'(g2);
      r.blk[0] = sample_t'(b0);
      r.blk[1] = sample_t'(b1);
      r.blk[2] = sample_t'(b2);
      r.blk[3] = sample_t'(b3);
      rows.push_back(r);
   endfunction

   function automatic void random_row();
      row_t r;
      r      = '0;
      r.kind = K_RND;
      rows.push_back(r);
   endfunction

   `include "tb_dsp_vectors.svh"

   // lcg step, 11 bit slice keeps six summed channels in range
   function automatic sample_t lcg_sample();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return sample_t'($signed(seed[26:16]));
   endfunction

   function automatic sample_t clamp14(input int v);
      if (v > 8191) return sample_t'(8191);
      if (v < -8192) return sample_t'(-8192);
      return sample_t'(v);
   endfunction

   // d = 0 dac a, d = 1 dac b
   function automatic sample_t dac_model(input int d);
      int acc;
      acc = 0;
      for (int c = 0; c < N_BLOCKS; c++) begin
         if (m_out_sel[c][d]) acc += int'(blk_out_i[c]);
      end
      if (m_out_sel[N_BLOCKS][d]) acc += int'(asg1_i);
      if (m_out_sel[N_BLOCKS+1][d]) acc += int'(asg2_i);
      return clamp14(acc);
   endfunction

   function automatic sample_t source_model(input sel_t idx);
      int i;
      i = int'(idx);
      if (i < N_BLOCKS) return blk_out_i[i];
      case (i - N_BLOCKS)
         SRC_ASG1:  return asg1_i;
         SRC_ASG2:  return asg2_i;
         SRC_ADC_A: return adc_a_i;
         SRC_ADC_B: return adc_b_i;
         SRC_DAC_A: return dac_model(0);
         SRC_DAC_B: return dac_model(1);
         default:   return '0;   // out of range or none
      endcase
   endfunction

   function automatic void track_write(input logic [31:0] addr, input logic [31:0] data);
      int slot;
      slot = int'(addr[19:16]);
      case (addr[15:0])
         REG_INPUT_SEL:  if (slot < N_BLOCKS + 4) m_in_sel[slot] = data[SEL_W-1:0];
         REG_OUTPUT_SEL: if (slot < N_BLOCKS + 2) m_out_sel[slot] = data[1:0];
         REG_SYNC:       m_sync = data[N_BLOCKS-1:0];
         default: ;
      endcase
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_outputs();
      for (int k = 0; k < N_BLOCKS; k++) begin
         check(32'(blk_in_o[k]), 32'(source_model(m_in_sel[k])), "block input");
      end
      check(32'(scope1_o), 32'(source_model(m_in_sel[N_BLOCKS+SNK_SCOPE1])), "scope1");
      check(32'(scope2_o), 32'(source_model(m_in_sel[N_BLOCKS+SNK_SCOPE2])), "scope2");
      check(32'(pwm0_o), 32'(source_model(m_in_sel[N_BLOCKS+SNK_PWM0])), "pwm0");
      check(32'(pwm1_o), 32'(source_model(m_in_sel[N_BLOCKS+SNK_PWM1])), "pwm1");
      check(32'(dac_a_o), 32'(dac_model(0)), "dac a");
      check(32'(dac_b_o), 32'(dac_model(1)), "dac b");
      check(32'(sync_o), 32'(m_sync), "sync");
   endtask

   // one request cycle, ack expected on the following one
   task automatic bus_access(input row_t r);
      @(posedge clk_i);
      bus_req_i <= '{addr: r.addr, wdata: (r.kind == K_WR) ? r.data : '0,
                     wen: r.kind == K_WR, ren: r.kind == K_RD};
      @(posedge clk_i);
      bus_req_i <= '0;
      @(negedge clk_i);
      if (bus_rsp_o.ack !== 1'b1) begin
         $display("bus access to address %h was not acknowledged", r.addr);
         $display("** FAIL **");
         $fatal(1, "missing acknowledge");
      end
      check(32'(bus_rsp_o.err), 32'(r.err), "bus err");
      if (r.kind == K_RD) check(bus_rsp_o.rdata, r.data, "read data");
      else track_write(r.addr, r.data);
   endtask

   // hold inputs well past the adder latency, then compare
   task automatic hold_inputs(input row_t r);
      @(posedge clk_i);
      if (r.kind == K_RND) begin
         adc_a_i <= lcg_sample();
         adc_b_i <= lcg_sample();
         asg1_i  <= lcg_sample();
         asg2_i  <= lcg_sample();
         for (int k = 0; k < N_BLOCKS; k++) begin
            blk_out_i[k] <= lcg_sample();
         end
      end else begin
         adc_a_i   <= r.adc_a;
         adc_b_i   <= r.adc_b;
         asg1_i    <= r.asg1;
         asg2_i    <= r.asg2;
         blk_out_i <= r.blk;
      end
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      check_outputs();
   endtask

   initial begin
      rstn_i    = 1'b0;
      adc_a_i   = '0;
      adc_b_i   = '0;
      asg1_i    = '0;
      asg2_i    = '0;
      blk_out_i = '0;
      bus_req_i = '0;
      for (int k = 0; k <= N_BLOCKS + SNK_SCOPE1; k++) begin
         m_in_sel[k] = sel_t'(N_BLOCKS + SRC_ADC_A);  // blocks and scope1
      end
      m_in_sel[N_BLOCKS+SNK_SCOPE2] = sel_t'(N_BLOCKS + SRC_ADC_B);
      m_in_sel[N_BLOCKS+SNK_PWM0]   = NONE_SEL;
      m_in_sel[N_BLOCKS+SNK_PWM1]   = NONE_SEL;
      for (int k = 0; k < N_BLOCKS + 2; k++) begin
         m_out_sel[k] = OUT_OFF;
      end
      m_sync = '1;
      build_table();
      repeat (2) @(posedge clk_i);
      rstn_i <= 1'b1;
      foreach (rows[i]) begin
         if (rows[i].kind == K_WR || rows[i].kind == K_RD) bus_access(rows[i]);
         else hold_inputs(rows[i]);
      end
      $display("** PASS **");
      $finish;
   end

   // watchdog, sized from the table length
   initial begin
      #1;
      repeat (rows.size() * 12 + 100) @(posedge clk_i);
      $display("** FAIL **");
      $fatal(1, "watchdog timeout, the test table did not complete");
   end

endmodule

// ==== src.f ====
+incdir+testbench
verilog/dsp_pkg.sv
verilog/dsp_regs.sv
verilog/dsp_router.sv
verilog/dac_sum_tree.sv
verilog/dsp_hub.sv
testbench/tb_dsp_hub.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dsp hub testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tb_dsp_hub -Mdir obj_dir &&
./obj_dir/Vtb_dsp_hub || { echo "simulation failed"; exit 1; }
